/* flist.f */
src/host_chan_pkg.sv
src/host_chan_if.sv
src/afu_port_shim.sv
src/host_chan_mux.sv
src/host_mem_model.sv
src/plat_top.sv
verif/tb_plat_top.sv

/* Makefile */
# Verilator flow for the two-port host channel platform

VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing --assert
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
TB_TOP     = tb_plat_top
RTL_TOP    = plat_top
FILELIST   = flist.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_TEXT  = sim passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/tb_plat_top.sv */
// Directed testbench for the two-port host channel platform
// A reference memory and per-port queues predict every response
module tb_plat_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_DEPTH   = 256;
    localparam int MEM_LATENCY = 4;
    localparam int FIFO_DEPTH  = 4;
    // About 150 requests at MEM_LATENCY+4 cycles each, with margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int A_W = host_chan_pkg::ADDR_W;
    localparam int D_W = host_chan_pkg::DATA_W;
    localparam int T_W = host_chan_pkg::TAG_W;

    typedef struct {
        host_chan_pkg::t_req_kind kind;
        logic [D_W-1:0]           data;
        logic [T_W-1:0]           tag;
    } exp_rsp_t;

    logic pclk;
    logic arst_n;
    logic afu0_req_valid, afu0_almost_full, afu0_rsp_valid;
    logic afu1_req_valid, afu1_almost_full, afu1_rsp_valid;
    host_chan_pkg::t_req_kind afu0_req_kind, afu0_rsp_kind, afu1_req_kind, afu1_rsp_kind;
    logic [A_W-1:0] afu0_req_addr, afu1_req_addr;
    logic [D_W-1:0] afu0_req_data, afu0_rsp_data, afu1_req_data, afu1_rsp_data;
    logic [T_W-1:0] afu0_req_tag, afu0_rsp_tag, afu1_req_tag, afu1_rsp_tag;

    // Reference memory, written the moment a write is issued
    logic [D_W-1:0] ref_mem [MEM_DEPTH];
    bit             ref_written [MEM_DEPTH];
    logic [A_W-1:0] shared_addr [8];

    exp_rsp_t exp_q0 [$];
    exp_rsp_t exp_q1 [$];
    logic [T_W-1:0] tag_cnt0, tag_cnt1;
    int seed;
    int cycle_cnt;

    plat_top #(
        .MEM_DEPTH   (MEM_DEPTH),
        .MEM_LATENCY (MEM_LATENCY),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) dut (.*);

    initial
    begin
        pclk = 1'b0;
        forever #50 pclk = ~pclk;
    end

    // ==============================
    // Run control and compare tasks
    // ==============================

    task automatic finish_run(input bit ok);
        if (ok)
        begin
            $display("sim passed");
            $finish;
        end
        else
        begin
            $display("sim failed");
            $fatal(1, "Run stopped at first error");
        end
    endtask

    task automatic check_kind(input string name, input host_chan_pkg::t_req_kind exp,
                              input host_chan_pkg::t_req_kind got);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s expected %s got %s", $time, name,
                     exp.name(), got.name());
            finish_run(1'b0);
        end
    endtask

    task automatic check_data(input string name, input logic [D_W-1:0] exp,
                              input logic [D_W-1:0] got);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
            finish_run(1'b0);
        end
    endtask

    task automatic check_tag(input string name, input logic [T_W-1:0] exp,
                             input logic [T_W-1:0] got);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
            finish_run(1'b0);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
            finish_run(1'b0);
        end
    endtask

    always @(posedge pclk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles with responses still missing", cycle_cnt);
            finish_run(1'b0);
        end
    end

    // ==============================
    // Response monitor
    // ==============================

    // Pops the oldest expectation of the port and compares the response with it
    task automatic take_rsp(input int port, input host_chan_pkg::t_req_kind kind,
                            input logic [D_W-1:0] data, input logic [T_W-1:0] tag);
        exp_rsp_t exp;
        int       depth;
        depth = (port == 0) ? exp_q0.size() : exp_q1.size();
        if (depth == 0)
        begin
            $display("Response on port %0d at %0t with no request outstanding", port, $time);
            finish_run(1'b0);
        end
        else
        begin
            if (port == 0)
            begin
                exp = exp_q0.pop_front();
            end
            else
            begin
                exp = exp_q1.pop_front();
            end
            check_kind($sformatf("afu%0d_rsp_kind", port), exp.kind, kind);
            check_tag($sformatf("afu%0d_rsp_tag", port), exp.tag, tag);
            // Write acknowledgements carry no data worth comparing
            if (exp.kind == host_chan_pkg::REQ_RD)
            begin
                check_data($sformatf("afu%0d_rsp_data", port), exp.data, data);
            end
        end
    endtask

    // Outputs are sampled mid-cycle, well away from the driving edge
    always @(negedge pclk)
    begin
        if (arst_n === 1'b1)
        begin
            if (afu0_rsp_valid === 1'b1)
            begin
                take_rsp(0, afu0_rsp_kind, afu0_rsp_data, afu0_rsp_tag);
            end
            if (afu1_rsp_valid === 1'b1)
            begin
                take_rsp(1, afu1_rsp_kind, afu1_rsp_data, afu1_rsp_tag);
            end
        end
    end

    // ==============================
    // Request drivers
    // ==============================

    // Moves to the next drive point and drops both request strobes
    task automatic advance();
        @(posedge pclk);
        #5;
        afu0_req_valid = 1'b0;
        afu1_req_valid = 1'b0;
    endtask

    // An unknown level counts as full
    function automatic bit port_full(input int port);
        return (port == 0) ? (afu0_almost_full !== 1'b0) : (afu1_almost_full !== 1'b0);
    endfunction

    task automatic wait_room(input int port);
        advance();
        while (port_full(port))
        begin
            advance();
        end
    endtask

    // Drives one request and records the response it must produce
    task automatic put_req(input int port, input host_chan_pkg::t_req_kind kind,
                           input logic [A_W-1:0] addr, input logic [D_W-1:0] data);
        exp_rsp_t exp;
        exp.kind = kind;
        exp.data = ref_mem[int'(addr)];
        exp.tag  = (port == 0) ? tag_cnt0 : tag_cnt1;
        if (kind == host_chan_pkg::REQ_WR)
        begin
            ref_mem[int'(addr)]     = data;
            ref_written[int'(addr)] = 1'b1;
        end
        if (port == 0)
        begin
            afu0_req_valid = 1'b1;
            afu0_req_kind  = kind;
            afu0_req_addr  = addr;
            afu0_req_data  = data;
            afu0_req_tag   = tag_cnt0;
            tag_cnt0++;
            exp_q0.push_back(exp);
        end
        else
        begin
            afu1_req_valid = 1'b1;
            afu1_req_kind  = kind;
            afu1_req_addr  = addr;
            afu1_req_data  = data;
            afu1_req_tag   = tag_cnt1;
            tag_cnt1++;
            exp_q1.push_back(exp);
        end
    endtask

    // Reads go only to words already written, otherwise the request turns into a write
    task automatic random_req(input int port, input logic [A_W-1:0] base);
        logic [31:0]              r;
        logic [A_W-1:0]           addr;
        host_chan_pkg::t_req_kind kind;
        r    = $random(seed);
        addr = base + A_W'(r[5:0]);
        kind = r[8] ? host_chan_pkg::REQ_WR : host_chan_pkg::REQ_RD;
        if (kind == host_chan_pkg::REQ_RD && !ref_written[int'(addr)])
        begin
            kind = host_chan_pkg::REQ_WR;
        end
        put_req(port, kind, addr, $random(seed));
    endtask

    // Waits for every outstanding response, then watches a while for strays
    task automatic drain();
        while (exp_q0.size() != 0 || exp_q1.size() != 0)
        begin
            advance();
        end
        repeat (MEM_LATENCY + 4) advance();
    endtask

    // Both ports issue once every gap cycles, port 0 low in memory and port 1 above it
    task automatic run_traffic(input int count, input int gap, output int stalls);
        int left0;
        int left1;
        int idle;
        left0  = count;
        left1  = count;
        idle   = 0;
        stalls = 0;
        while (left0 > 0 || left1 > 0)
        begin
            advance();
            if (idle > 0)
            begin
                idle--;
            end
            else
            begin
                idle = gap - 1;
                if (left0 > 0 && port_full(0))
                    stalls++;
                else if (left0 > 0)
                begin
                    random_req(0, A_W'(16'h0080));
                    left0--;
                end
                if (left1 > 0 && port_full(1))
                    stalls++;
                else if (left1 > 0)
                begin
                    random_req(1, A_W'(16'h00c0));
                    left1--;
                end
            end
        end
        drain();
    endtask

    // ==============================
    // Directed tests
    // ==============================

    task automatic test_reset_state();
        check_flag("afu0_almost_full", 1'b0, afu0_almost_full);
        check_flag("afu1_almost_full", 1'b0, afu1_almost_full);
        check_flag("afu0_rsp_valid", 1'b0, afu0_rsp_valid);
        check_flag("afu1_rsp_valid", 1'b0, afu1_rsp_valid);
    endtask

    task automatic test_port0_round_trip();
        for (int i = 0; i < 8; i++)
        begin
            wait_room(0);
            shared_addr[i] = A_W'($random(seed) & 32'h3f);
            put_req(0, host_chan_pkg::REQ_WR, shared_addr[i], $random(seed));
        end
        for (int i = 0; i < 8; i++)
        begin
            wait_room(0);
            put_req(0, host_chan_pkg::REQ_RD, shared_addr[i], '0);
        end
        drain();
    endtask

    // Port 1 sees port 0's writes, then port 0 reads what port 1 wrote
    task automatic test_shared_memory();
        for (int i = 0; i < 8; i++)
        begin
            wait_room(1);
            put_req(1, host_chan_pkg::REQ_RD, shared_addr[i], '0);
        end
        for (int i = 0; i < 4; i++)
        begin
            wait_room(1);
            put_req(1, host_chan_pkg::REQ_WR, A_W'(32'h40 + i), $random(seed));
        end
        drain();
        for (int i = 0; i < 4; i++)
        begin
            wait_room(0);
            put_req(0, host_chan_pkg::REQ_RD, A_W'(32'h40 + i), '0);
        end
        drain();
    endtask

    task automatic test_concurrent_traffic();
        int stalls;
        run_traffic(24, 2, stalls);
    endtask

    // Back to back on both ports, so each one drains at half rate and fills up
    task automatic test_back_pressure();
        int stalls;
        run_traffic(32, 1, stalls);
        if (stalls == 0)
        begin
            $display("Back-pressure test never saw almost_full raised");
            finish_run(1'b0);
        end
    endtask

    initial
    begin
        {afu0_req_valid, afu0_req_addr, afu0_req_data, afu0_req_tag} = '0;
        {afu1_req_valid, afu1_req_addr, afu1_req_data, afu1_req_tag} = '0;
        afu0_req_kind = host_chan_pkg::REQ_RD;
        afu1_req_kind = host_chan_pkg::REQ_RD;
        tag_cnt0 = '0;
        tag_cnt1 = '0;
        cycle_cnt = 0;
        seed = 32'h1e32;
        for (int i = 0; i < MEM_DEPTH; i++)
        begin
            ref_written[i] = 1'b0;
        end
        arst_n = 1'b0;
        repeat (10) @(posedge pclk);
        #5;
        arst_n = 1'b1;
        test_reset_state();
        test_port0_round_trip();
        test_shared_memory();
        test_concurrent_traffic();
        test_back_pressure();
        finish_run(1'b1);
    end

endmodule

/* src/plat_top.sv */
// Platform top with two AFU ports sharing one host memory channel through
// per-port shims and a round-robin multiplexer
module plat_top #(
    parameter int MEM_DEPTH   = 256,
    parameter int MEM_LATENCY = 4,
    parameter int FIFO_DEPTH  = 4
) (
    input  logic                             pclk,
    input  logic                             arst_n,

    // AFU port 0
    input  logic                             afu0_req_valid,
    input  host_chan_pkg::t_req_kind         afu0_req_kind,
    input  logic [host_chan_pkg::ADDR_W-1:0] afu0_req_addr,
    input  logic [host_chan_pkg::DATA_W-1:0] afu0_req_data,
    input  logic [host_chan_pkg::TAG_W-1:0]  afu0_req_tag,
    output logic                             afu0_almost_full,
    output logic                             afu0_rsp_valid,
    output host_chan_pkg::t_req_kind         afu0_rsp_kind,
    output logic [host_chan_pkg::DATA_W-1:0] afu0_rsp_data,
    output logic [host_chan_pkg::TAG_W-1:0]  afu0_rsp_tag,

    // AFU port 1
    input  logic                             afu1_req_valid,
    input  host_chan_pkg::t_req_kind         afu1_req_kind,
    input  logic [host_chan_pkg::ADDR_W-1:0] afu1_req_addr,
    input  logic [host_chan_pkg::DATA_W-1:0] afu1_req_data,
    input  logic [host_chan_pkg::TAG_W-1:0]  afu1_req_tag,
    output logic                             afu1_almost_full,
    output logic                             afu1_rsp_valid,
    output host_chan_pkg::t_req_kind         afu1_rsp_kind,
    output logic [host_chan_pkg::DATA_W-1:0] afu1_rsp_data,
    output logic [host_chan_pkg::TAG_W-1:0]  afu1_rsp_tag
);

    // One channel per shim and the shared channel to memory
    host_chan_if shim0_ch ();
    host_chan_if shim1_ch ();
    host_chan_if mem_ch ();

    // ============================
    // Port shims
    // ============================

    afu_port_shim #(
        .PORT_ID    (0),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) shim0 (
        .pclk        (pclk),
        .arst_n      (arst_n),
        .req_valid   (afu0_req_valid),
        .req_kind    (afu0_req_kind),
        .req_addr    (afu0_req_addr),
        .req_data    (afu0_req_data),
        .req_tag     (afu0_req_tag),
        .almost_full (afu0_almost_full),
        .rsp_valid   (afu0_rsp_valid),
        .rsp_kind    (afu0_rsp_kind),
        .rsp_data    (afu0_rsp_data),
        .rsp_tag     (afu0_rsp_tag),
        .host        (shim0_ch.to_host)
    );

    afu_port_shim #(
        .PORT_ID    (1),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) shim1 (
        .pclk        (pclk),
        .arst_n      (arst_n),
        .req_valid   (afu1_req_valid),
        .req_kind    (afu1_req_kind),
        .req_addr    (afu1_req_addr),
        .req_data    (afu1_req_data),
        .req_tag     (afu1_req_tag),
        .almost_full (afu1_almost_full),
        .rsp_valid   (afu1_rsp_valid),
        .rsp_kind    (afu1_rsp_kind),
        .rsp_data    (afu1_rsp_data),
        .rsp_tag     (afu1_rsp_tag),
        .host        (shim1_ch.to_host)
    );

    // ============================
    // Shared channel and memory
    // ============================

    host_chan_mux chan_mux (
        .pclk   (pclk),
        .arst_n (arst_n),
        .shim0  (shim0_ch.to_afu),
        .shim1  (shim1_ch.to_afu),
        .mem    (mem_ch.to_host)
    );

    host_mem_model #(
        .MEM_DEPTH   (MEM_DEPTH),
        .MEM_LATENCY (MEM_LATENCY)
    ) mem_model (
        .pclk   (pclk),
        .arst_n (arst_n),
        .host   (mem_ch.to_afu)
    );

endmodule

/* src/host_mem_model.sv */
// Host memory model serving reads and writes after a fixed latency,
// fully pipelined, echoing each request's metadata with its response
module host_mem_model #(
    parameter int MEM_DEPTH   = 256,
    parameter int MEM_LATENCY = 4
) (
    input  logic        pclk,
    input  logic        arst_n,

    host_chan_if.to_afu host
);

    localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

    logic [host_chan_pkg::DATA_W-1:0] mem_array [MEM_DEPTH];

    // Response pipeline, stage 0 is loaded at acceptance
    logic                             pipe_valid [MEM_LATENCY];
    host_chan_pkg::t_req_kind         pipe_kind  [MEM_LATENCY];
    logic [host_chan_pkg::DATA_W-1:0] pipe_data  [MEM_LATENCY];
    logic [host_chan_pkg::MDATA_W-1:0] pipe_mdata [MEM_LATENCY];

    logic [IDX_W-1:0]                 req_idx;
    logic [host_chan_pkg::DATA_W-1:0] rd_word;
    logic                             wr_en;
    host_chan_pkg::t_mdata            out_mdata;

    // ============================
    // Array access
    // ============================

    assign req_idx = host.req_addr[IDX_W-1:0];
    assign wr_en   = host.req_valid && (host.req_kind == host_chan_pkg::REQ_WR);

    // Read data is taken before any write on the same edge lands
    assign rd_word = mem_array[req_idx];

    always_ff @(posedge pclk)
    begin
        if (wr_en)
        begin
            mem_array[req_idx] <= host.req_data;
        end
    end

    // The model never pushes back
    assign host.almost_full = 1'b0;

    // ============================
    // Latency pipeline
    // ============================

    always_ff @(posedge pclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < MEM_LATENCY; i++)
            begin
                pipe_valid[i] <= 1'b0;
            end
        end
        else
        begin
            pipe_valid[0] <= host.req_valid;
            for (int i = 1; i < MEM_LATENCY; i++)
            begin
                pipe_valid[i] <= pipe_valid[i-1];
            end
        end
    end

    // Write acknowledgements return zero data
    always_ff @(posedge pclk)
    begin
        pipe_kind[0]  <= host.req_kind;
        pipe_data[0]  <= (host.req_kind == host_chan_pkg::REQ_RD) ? rd_word : '0;
        pipe_mdata[0] <= host.req_mdata.raw;
        for (int i = 1; i < MEM_LATENCY; i++)
        begin
            pipe_kind[i]  <= pipe_kind[i-1];
            pipe_data[i]  <= pipe_data[i-1];
            pipe_mdata[i] <= pipe_mdata[i-1];
        end
    end

    // Metadata goes back bit for bit, the model never looks inside it
    always_comb
    begin
        out_mdata.raw = pipe_mdata[MEM_LATENCY-1];
    end

    assign host.rsp_valid = pipe_valid[MEM_LATENCY-1];
    assign host.rsp_kind  = pipe_kind[MEM_LATENCY-1];
    assign host.rsp_data  = pipe_data[MEM_LATENCY-1];
    assign host.rsp_mdata = out_mdata;

    // Upper address bits are dropped by the index, so they must be zero
    a_addr_in_range : assert property (
        @(posedge pclk) disable iff (!arst_n)
        host.req_valid |-> (host.req_addr < host_chan_pkg::ADDR_W'(MEM_DEPTH))
    );

endmodule

/* src/host_chan_mux.sv */
// Round-robin multiplexer of two port shims onto the shared host channel,
// routing each response back by the port index in its metadata
module host_chan_mux (
    input  logic        pclk,
    input  logic        arst_n,

    host_chan_if.to_afu shim0,
    host_chan_if.to_afu shim1,

    host_chan_if.to_host mem
);

    // Priority bit, high when shim1 wins a tie
    logic       prio;
    logic [1:0] grant;

    // Registered request toward the memory model
    logic                             out_valid;
    host_chan_pkg::t_req_kind         out_kind;
    logic [host_chan_pkg::ADDR_W-1:0] out_addr;
    logic [host_chan_pkg::DATA_W-1:0] out_data;
    host_chan_pkg::t_mdata            out_mdata;

    logic [host_chan_pkg::PORT_W-1:0] rsp_port;

    // ============================
    // Arbitration
    // ============================

    // One request per cycle, and only when the channel has room
    always_comb
    begin
        grant = 2'b00;
        if (!mem.almost_full)
        begin
            if (shim0.req_valid && shim1.req_valid)
            begin
                grant = prio ? 2'b10 : 2'b01;
            end
            else
            begin
                grant = {shim1.req_valid, shim0.req_valid};
            end
        end
    end

    // A waiting shim sees almost_full until the cycle it is granted
    // and pops its head on that cycle
    assign shim0.almost_full = shim0.req_valid && !grant[0];
    assign shim1.almost_full = shim1.req_valid && !grant[1];

    // The loser of this cycle wins the next tie
    always_ff @(posedge pclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            prio      <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            if (grant[0])
            begin
                prio <= 1'b1;
            end
            else if (grant[1])
            begin
                prio <= 1'b0;
            end
            out_valid <= |grant;
        end
    end

    // Payload follows the grant, valid qualifies it
    always_ff @(posedge pclk)
    begin
        if (grant[1])
        begin
            out_kind  <= shim1.req_kind;
            out_addr  <= shim1.req_addr;
            out_data  <= shim1.req_data;
            out_mdata <= shim1.req_mdata;
        end
        else if (grant[0])
        begin
            out_kind  <= shim0.req_kind;
            out_addr  <= shim0.req_addr;
            out_data  <= shim0.req_data;
            out_mdata <= shim0.req_mdata;
        end
    end

    assign mem.req_valid = out_valid;
    assign mem.req_kind  = out_kind;
    assign mem.req_addr  = out_addr;
    assign mem.req_data  = out_data;
    assign mem.req_mdata = out_mdata;

    // ============================
    // Response routing
    // ============================

    // Port index written by the shim comes back untouched from memory
    assign rsp_port = mem.rsp_mdata.fields.port;

    assign shim0.rsp_valid = mem.rsp_valid && (rsp_port == host_chan_pkg::PORT_W'(0));
    assign shim1.rsp_valid = mem.rsp_valid && (rsp_port == host_chan_pkg::PORT_W'(1));

    // Payload is shared, only the strobe picks the port
    assign shim0.rsp_kind  = mem.rsp_kind;
    assign shim0.rsp_data  = mem.rsp_data;
    assign shim0.rsp_mdata = mem.rsp_mdata;
    assign shim1.rsp_kind  = mem.rsp_kind;
    assign shim1.rsp_data  = mem.rsp_data;
    assign shim1.rsp_mdata = mem.rsp_mdata;

    // Grants never overlap, and a shim passed over while waiting goes next
    a_grant_onehot0 : assert property (
        @(posedge pclk) disable iff (!arst_n)
        $onehot0(grant)
        && !($past(grant[0] && shim1.req_valid) && !mem.almost_full && !grant[1])
        && !($past(grant[1] && shim0.req_valid) && !mem.almost_full && !grant[0])
    );

    // A response for a port nobody owns would vanish silently
    a_rsp_port_known : assert property (
        @(posedge pclk) disable iff (!arst_n)
        mem.rsp_valid |-> (rsp_port <= host_chan_pkg::PORT_W'(1))
    );

endmodule

/* src/afu_port_shim.sv */
// Per-port shim that buffers AFU requests, tags them with the port index and
// returns responses to the AFU with the port index stripped
module afu_port_shim #(
    parameter int PORT_ID    = 0,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                             pclk,
    input  logic                             arst_n,

    // AFU request side
    input  logic                             req_valid,
    input  host_chan_pkg::t_req_kind         req_kind,
    input  logic [host_chan_pkg::ADDR_W-1:0] req_addr,
    input  logic [host_chan_pkg::DATA_W-1:0] req_data,
    input  logic [host_chan_pkg::TAG_W-1:0]  req_tag,

    // AFU response side
    output logic                             almost_full,
    output logic                             rsp_valid,
    output host_chan_pkg::t_req_kind         rsp_kind,
    output logic [host_chan_pkg::DATA_W-1:0] rsp_data,
    output logic [host_chan_pkg::TAG_W-1:0]  rsp_tag,

    host_chan_if.to_host                     host
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // Request storage, one entry per buffered request
    host_chan_pkg::t_req_kind         buf_kind [FIFO_DEPTH];
    logic [host_chan_pkg::ADDR_W-1:0] buf_addr [FIFO_DEPTH];
    logic [host_chan_pkg::DATA_W-1:0] buf_data [FIFO_DEPTH];
    logic [host_chan_pkg::TAG_W-1:0]  buf_tag  [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic                  push;
    logic                  pop;
    host_chan_pkg::t_mdata head_mdata;

    // ============================
    // Buffer control
    // ============================

    // Every strobe from the AFU is taken, the AFU watches almost_full
    assign push = req_valid;

    // The multiplexer drops almost_full for one cycle when it takes the head
    assign pop = host.req_valid && !host.almost_full;

    // Raised with one slot or fewer free, so a request already in flight fits
    assign almost_full = (count >= CNT_W'(FIFO_DEPTH - 1));

    always_ff @(posedge pclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Payload entries carry no reset, count qualifies them
    always_ff @(posedge pclk)
    begin
        if (push)
        begin
            buf_kind[wr_ptr] <= req_kind;
            buf_addr[wr_ptr] <= req_addr;
            buf_data[wr_ptr] <= req_data;
            buf_tag[wr_ptr]  <= req_tag;
        end
    end

    // ============================
    // Host side
    // ============================

    // Port index goes in next to the AFU tag so responses can find their way back
    always_comb
    begin
        head_mdata.fields.port = host_chan_pkg::PORT_W'(PORT_ID);
        head_mdata.fields.tag  = buf_tag[rd_ptr];
    end

    // The head entry is offered whenever the buffer holds anything
    assign host.req_valid = (count != '0);
    assign host.req_kind  = buf_kind[rd_ptr];
    assign host.req_addr  = buf_addr[rd_ptr];
    assign host.req_data  = buf_data[rd_ptr];
    assign host.req_mdata = head_mdata;

    // Responses go straight back in the same cycle, only the AFU tag survives
    assign rsp_valid = host.rsp_valid;
    assign rsp_kind  = host.rsp_kind;
    assign rsp_data  = host.rsp_data;
    assign rsp_tag   = host.rsp_mdata.fields.tag;

    // The AFU must have stopped before the buffer filled up
    a_no_push_when_full : assert property (
        @(posedge pclk) disable iff (!arst_n)
        !(push && (count == CNT_W'(FIFO_DEPTH)))
    );

endmodule

/* src/host_chan_if.sv */
// Request and response channel between an AFU-side requester and a host-side
// responder, with strobe handshakes and an almost_full level
interface host_chan_if;

    // Request path, driven from the AFU side
    logic                             req_valid;
    host_chan_pkg::t_req_kind         req_kind;
    logic [host_chan_pkg::ADDR_W-1:0] req_addr;
    logic [host_chan_pkg::DATA_W-1:0] req_data;
    host_chan_pkg::t_mdata            req_mdata;

    // Flow control, driven from the host side
    logic                             almost_full;

    // Response path, driven from the host side and never back-pressured
    logic                             rsp_valid;
    host_chan_pkg::t_req_kind         rsp_kind;
    logic [host_chan_pkg::DATA_W-1:0] rsp_data;
    host_chan_pkg::t_mdata            rsp_mdata;

    // Requester view
    modport to_host (
        output req_valid, req_kind, req_addr, req_data, req_mdata,
        input  almost_full,
        input  rsp_valid, rsp_kind, rsp_data, rsp_mdata
    );

    // Responder view
    modport to_afu (
        input  req_valid, req_kind, req_addr, req_data, req_mdata,
        output almost_full,
        output rsp_valid, rsp_kind, rsp_data, rsp_mdata
    );

endinterface

/* src/host_chan_pkg.sv */
// Host channel definitions shared by the port shims, the channel multiplexer
// and the host memory model
package host_chan_pkg;

    // ============================
    // Field widths
    // ============================

    // Word address and data
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // AFU tag and port index, both carried in the metadata word
    localparam int TAG_W  = 8;
    localparam int PORT_W = 2;
    localparam int MDATA_W = PORT_W + TAG_W;

    // Kind of a request, and also the kind of the matching response
    typedef enum logic [0:0] {
        REQ_RD = 1'b0,
        REQ_WR = 1'b1
    } t_req_kind;

    // Metadata as decoded by the shims and the multiplexer
    typedef struct packed {
        logic [PORT_W-1:0] port;
        logic [TAG_W-1:0]  tag;
    } t_mdata_fields;

    // The memory model only ever sees the raw word and echoes it back
    typedef union packed {
        logic [MDATA_W-1:0] raw;
        t_mdata_fields      fields;
    } t_mdata;

endpackage
